// ==== clk_mgr_top.f ====
rtl/clk_mgr_pkg.sv
rtl/status_if.sv
rtl/cmd_deser.sv
rtl/clk_source.sv
rtl/clk_ctrl.sv
rtl/status_generate.sv
rtl/clk_mgr_top.sv
verification/tb_clk_gen.sv
verification/tb_clk_mgr.sv

// ==== rtl/clk_ctrl.sv ====
// clock controller below the top level with control registers, clock sources and time reference
`timescale 1ns/100ps

module clk_ctrl #(
    parameter logic [clk_mgr_pkg::NUM_SRC-1:0] CLK_RESET_INIT = '0,
    parameter int                              PCLK_DIV       = 4,
    parameter int                              XCLK_DIV       = 2,
    parameter int                              LOCK_CYCLES    = 16
) (
    input  logic                              mclk,
    input  logic                              ffclk0_rst,
    input  logic                              cmd_we_i,
    input  logic                              cmd_reg_i,
    input  clk_mgr_pkg::cmd_word_t            cmd_data_i,
    input  logic                              ffclk0_i,       // external sensor clock
    input  logic [1:0]                        extra_status_i,
    output logic                              pclk_o,
    output logic                              xclk_o,
    output logic [clk_mgr_pkg::NUM_SRC-1:0]   locked_o,       // [0] pclk, [1] xclk
    output logic                              time_ref_o,     // mclk/8
    status_if.ctrl                            stat
);
    localparam int NS      = clk_mgr_pkg::NUM_SRC;
    localparam int ALIVE_W = 5;  // width of the idle counter that saturates at 31 quiet cycles

    logic [NS-1:0] src_rst_r;    // reset bits from ctrl register
    logic [NS-1:0] pwrdwn_r;     // power-down bits from ctrl register
    logic [NS-1:0] src_rst;      // with global reset merged
    logic          tgl_ff0;      // toggles on ffclk0_i
    logic          tgl_pclk;     // toggles on pclk_o
    logic [3:0]    sync1;        // first stage of {tgl_ff0, tgl_pclk, locked}
    logic [3:0]    sync2;        // second stage safe to use in mclk
    logic [1:0]    alive;        // [1] ffclk0, [0] pclk
    logic [2:0]    time_cnt;
    logic          wr_ctrl;
    logic          wr_stat;

    assign src_rst = src_rst_r | {NS{ffclk0_rst}};
    assign wr_ctrl = cmd_we_i && (cmd_reg_i == clk_mgr_pkg::REG_CTRL);
    assign wr_stat = cmd_we_i && (cmd_reg_i == clk_mgr_pkg::REG_STAT);

    always_ff @(posedge mclk or posedge ffclk0_rst) begin
        if (ffclk0_rst) begin
            src_rst_r      <= CLK_RESET_INIT;
            pwrdwn_r       <= '0;
            stat.stat_we   <= 1'b0;
            stat.stat_mode <= clk_mgr_pkg::STAT_OFF;
            stat.stat_seq  <= '0;
        end else begin
            stat.stat_we <= wr_stat;                  // lines up with new mode/seq
            if (wr_ctrl) begin
                src_rst_r <= cmd_data_i.ctrl.rst;     // ctrl view
                pwrdwn_r  <= cmd_data_i.ctrl.pwrdwn;
            end
            if (wr_stat) begin
                stat.stat_mode <= cmd_data_i.stat.mode; // stat view
                stat.stat_seq  <= cmd_data_i.stat.seq;
            end
        end
    end

    // running checks that both follow the pclk source reset
    always_ff @(posedge ffclk0_i or posedge src_rst[0]) begin
        if (src_rst[0]) tgl_ff0 <= 1'b0;
        else            tgl_ff0 <= ~tgl_ff0;
    end

    always_ff @(posedge pclk_o or posedge src_rst[0]) begin
        if (src_rst[0]) tgl_pclk <= 1'b0;
        else            tgl_pclk <= ~tgl_pclk;
    end

    always_ff @(posedge mclk or posedge ffclk0_rst) begin
        if (ffclk0_rst) begin
            sync1        <= '0;
            sync2        <= '0;
            stat.payload <= '0;
        end else begin
            sync1        <= {tgl_ff0, tgl_pclk, locked_o};  // two-flop crossing
            sync2        <= sync1;
            stat.payload <= {src_rst_r, alive, sync2[1:0], extra_status_i};
        end
    end

    // report a recent edge because a raw toggle would flip the payload every few cycles
    for (genvar i = 0; i < 2; i++) begin : g_alive
        logic               tgl_d;     // last synced toggle value
        logic [ALIVE_W-1:0] idle_cnt;  // mclk cycles since last edge

        always_ff @(posedge mclk or posedge ffclk0_rst) begin
            if (ffclk0_rst) begin
                tgl_d    <= 1'b0;
                idle_cnt <= '1;                        // stopped until an edge shows
            end else begin
                tgl_d <= sync2[i+2];
                if (sync2[i+2] != tgl_d) idle_cnt <= '0;
                else if (idle_cnt != '1) idle_cnt <= idle_cnt + 1'b1;
            end
        end

        assign alive[i] = (idle_cnt != '1);
    end

    always_ff @(posedge mclk or posedge ffclk0_rst) begin
        if (ffclk0_rst) time_cnt <= '0;
        else            time_cnt <= time_cnt + 3'd1;
    end

    assign time_ref_o = time_cnt[2];   // 50% duty

    clk_source #(
        .DIV         (PCLK_DIV),
        .LOCK_CYCLES (LOCK_CYCLES)
    ) pclk_src_i (
        .ref_clk_i (ffclk0_i),
        .rst_i     (src_rst[0]),
        .pwrdwn_i  (pwrdwn_r[0]),
        .clk_o     (pclk_o),
        .locked_o  (locked_o[0])
    );

    clk_source #(
        .DIV         (XCLK_DIV),
        .LOCK_CYCLES (LOCK_CYCLES)
    ) xclk_src_i (
        .ref_clk_i (mclk),              // xclk built from the system clock
        .rst_i     (src_rst[1]),
        .pwrdwn_i  (pwrdwn_r[1]),
        .clk_o     (xclk_o),
        .locked_o  (locked_o[1])
    );

endmodule

// ==== rtl/clk_mgr_pkg.sv ====
// clock manager types and constants, referenced by scoped names from the design files
package clk_mgr_pkg;

    localparam int BYTE_W         = 8;   // command and status bus width
    localparam int CMD_DATA_W     = 11;  // used bits of the 16-bit command data
    localparam int NUM_SRC        = 2;   // [0] pclk, [1] xclk
    localparam int STAT_PAYLOAD_W = 8;   // {rst[1:0], alive ffclk0/pclk, locked[1:0], extra[1:0]}
    localparam int STAT_SEQ_W     = 6;   // sequence number, top of status byte 1

    // register index, command address bit 0
    localparam logic REG_CTRL = 1'b0;    // resets and power-down
    localparam logic REG_STAT = 1'b1;    // status mode and sequence

    typedef enum logic [1:0] {
        STAT_OFF    = 2'd0,              // no packets
        STAT_SINGLE = 2'd1,              // one packet per write
        STAT_AUTO   = 2'd3               // packet on every payload change
    } stat_mode_t;

    // ctrl register view of the command word
    typedef struct packed {
        logic [CMD_DATA_W-2*NUM_SRC-1:0] rsvd;
        logic [NUM_SRC-1:0]              pwrdwn; // per source power-down
        logic [NUM_SRC-1:0]              rst;    // per source reset
    } ctrl_word_t;

    // status register view of the command word
    typedef struct packed {
        logic [CMD_DATA_W-2-STAT_SEQ_W-1:0] rsvd;
        stat_mode_t                         mode;
        logic [STAT_SEQ_W-1:0]              seq;
    } stat_word_t;

    // one data word, meaning picked by the register index
    typedef union packed {
        ctrl_word_t ctrl;
        stat_word_t stat;
    } cmd_word_t;

endpackage

// ==== rtl/clk_mgr_top.sv ====
// clock manager top level: command input, clock controller and status output wired together
`timescale 1ns/100ps

module clk_mgr_top #(
    parameter logic [15:0]                     CLK_ADDR       = 16'h728, // 'h728..'h729
    parameter logic [15:0]                     CLK_MASK       = 16'h7fe,
    parameter logic [7:0]                      STATUS_ADDR    = 8'h3a,
    parameter logic [clk_mgr_pkg::NUM_SRC-1:0] CLK_RESET_INIT = '0,      // sources held after reset
    parameter int                              PCLK_DIV       = 4,
    parameter int                              XCLK_DIV       = 2,
    parameter int                              LOCK_CYCLES    = 16
) (
    input  logic                              mclk,            // system clock
    input  logic                              ffclk0_rst,      // async, active high
    input  logic [clk_mgr_pkg::BYTE_W-1:0]    cmd_ad_i,        // command bytes AL-AH-DL-DH
    input  logic                              cmd_stb_i,       // with AL
    output logic [clk_mgr_pkg::BYTE_W-1:0]    status_ad_o,     // A, {seq,st[1:0]}, st[7:2]
    output logic                              status_rq_o,
    input  logic                              status_start_i,
    input  logic                              ffclk0_i,        // external clock for pclk
    input  logic [1:0]                        extra_status_i,  // two spare status bits
    output logic                              pclk_o,
    output logic                              xclk_o,
    output logic [clk_mgr_pkg::NUM_SRC-1:0]   locked_o,        // [0] pclk, [1] xclk
    output logic                              time_ref_o
);
    logic                   cmd_we;
    logic                   cmd_reg;
    clk_mgr_pkg::cmd_word_t cmd_data;

    status_if stat_if ();   // controller to generator

    cmd_deser #(
        .CLK_ADDR (CLK_ADDR),
        .CLK_MASK (CLK_MASK)
    ) cmd_deser_i (
        .mclk       (mclk),
        .ffclk0_rst (ffclk0_rst),
        .cmd_ad_i   (cmd_ad_i),
        .cmd_stb_i  (cmd_stb_i),
        .cmd_we_o   (cmd_we),
        .cmd_reg_o  (cmd_reg),
        .cmd_data_o (cmd_data)
    );

    clk_ctrl #(
        .CLK_RESET_INIT (CLK_RESET_INIT),
        .PCLK_DIV       (PCLK_DIV),
        .XCLK_DIV       (XCLK_DIV),
        .LOCK_CYCLES    (LOCK_CYCLES)
    ) clk_ctrl_i (
        .mclk           (mclk),
        .ffclk0_rst     (ffclk0_rst),
        .cmd_we_i       (cmd_we),
        .cmd_reg_i      (cmd_reg),
        .cmd_data_i     (cmd_data),
        .ffclk0_i       (ffclk0_i),
        .extra_status_i (extra_status_i),
        .pclk_o         (pclk_o),
        .xclk_o         (xclk_o),
        .locked_o       (locked_o),
        .time_ref_o     (time_ref_o),
        .stat           (stat_if.ctrl)
    );

    status_generate #(
        .STATUS_ADDR (STATUS_ADDR)
    ) status_generate_i (
        .mclk           (mclk),
        .ffclk0_rst     (ffclk0_rst),
        .stat           (stat_if.gen),
        .status_ad_o    (status_ad_o),
        .status_rq_o    (status_rq_o),
        .status_start_i (status_start_i)
    );

endmodule

// ==== rtl/clk_source.sv ====
// behavioural PLL stand-in: even divider on the reference clock plus a lock counter
`timescale 1ns/100ps

module clk_source #(
    parameter int DIV         = 4,   // even, output period in reference cycles
    parameter int LOCK_CYCLES = 16   // clean reference edges before lock
) (
    input  logic ref_clk_i,
    input  logic rst_i,      // async, global reset or control bit
    input  logic pwrdwn_i,   // taken on the next reference edge
    output logic clk_o,
    output logic locked_o
);
    localparam int HALF = DIV / 2;
    localparam int DW   = $clog2(HALF + 1);
    localparam int LW   = $clog2(LOCK_CYCLES + 1);

    logic [DW-1:0] div_cnt;    // edges since last output toggle
    logic [LW-1:0] lock_cnt;   // saturates at LOCK_CYCLES

    assign locked_o = (lock_cnt == LW'(LOCK_CYCLES));

    always_ff @(posedge ref_clk_i or posedge rst_i) begin
        if (rst_i) begin
            div_cnt  <= '0;
            clk_o    <= 1'b0;
            lock_cnt <= '0;
        end else if (pwrdwn_i) begin
            div_cnt  <= '0;                // output parked low
            clk_o    <= 1'b0;
            lock_cnt <= '0;                // lock lost on this edge
        end else begin
            if (div_cnt == DW'(HALF - 1)) begin
                div_cnt <= '0;
                clk_o   <= ~clk_o;         // half period done
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (!locked_o) begin
                lock_cnt <= lock_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/cmd_deser.sv ====
// byte-serial command deserializer, four bytes per command, write pulse on address match
`timescale 1ns/100ps

module cmd_deser #(
    parameter logic [15:0] CLK_ADDR = 16'h728,
    parameter logic [15:0] CLK_MASK = 16'h7fe
) (
    input  logic                           mclk,
    input  logic                           ffclk0_rst,
    input  logic [clk_mgr_pkg::BYTE_W-1:0] cmd_ad_i,   // AL, AH, DL, DH
    input  logic                           cmd_stb_i,  // with AL only
    output logic                           cmd_we_o,   // cycle after DH
    output logic                           cmd_reg_o,  // address bit 0
    output clk_mgr_pkg::cmd_word_t         cmd_data_o
);
    localparam int BW = clk_mgr_pkg::BYTE_W;

    logic [3*BW-1:0] sr;         // AL at bottom once three bytes are in
    logic [1:0]      byte_cnt;   // bytes taken so far
    logic            busy;       // inside a command
    logic            last_byte;  // DH on the bus
    logic [2*BW-1:0] addr;
    logic [2*BW-1:0] data_w;     // full 16-bit data, top bits dropped
    logic            addr_hit;

    assign last_byte = busy && (byte_cnt == 2'd3);
    assign addr      = sr[2*BW-1:0];
    assign data_w    = {cmd_ad_i, sr[3*BW-1:2*BW]};
    assign addr_hit  = ((addr ^ CLK_ADDR) & CLK_MASK) == '0; // bit 0 is the register index

    always_ff @(posedge mclk or posedge ffclk0_rst) begin
        if (ffclk0_rst) begin
            busy     <= 1'b0;
            byte_cnt <= '0;
            cmd_we_o <= 1'b0;
        end else begin
            cmd_we_o <= last_byte && addr_hit;  // foreign addresses dropped here
            if (cmd_stb_i) begin
                busy     <= 1'b1;               // strobe restarts a command
                byte_cnt <= 2'd1;
            end else if (busy) begin
                byte_cnt <= byte_cnt + 2'd1;    // wraps to 0 after DH
                if (byte_cnt == 2'd3) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // byte shifter and data capture
    always_ff @(posedge mclk) begin
        if (cmd_stb_i || (busy && !last_byte)) begin
            sr <= {cmd_ad_i, sr[3*BW-1:BW]};    // newest byte enters at the top
        end
        if (last_byte) begin
            cmd_reg_o  <= addr[0];
            cmd_data_o <= data_w[clk_mgr_pkg::CMD_DATA_W-1:0];
        end
    end

endmodule

// ==== rtl/status_generate.sv ====
// status packet sequencer, three-byte packets on request in single or automatic mode
`timescale 1ns/100ps

module status_generate #(
    parameter logic [7:0] STATUS_ADDR = 8'h3a
) (
    input  logic                           mclk,
    input  logic                           ffclk0_rst,
    status_if.gen                          stat,
    output logic [clk_mgr_pkg::BYTE_W-1:0] status_ad_o,    // address, then two data bytes
    output logic                           status_rq_o,    // held until start
    input  logic                           status_start_i  // address byte taken
);
    localparam int PW = clk_mgr_pkg::STAT_PAYLOAD_W;

    typedef enum logic [1:0] {
        ST_IDLE,                     // address byte when pending
        ST_BYTE1,                    // {seq, payload[1:0]}
        ST_BYTE2                     // {2'b0, payload[7:2]}
    } seq_state_t;

    seq_state_t                         state;
    logic                               pending;    // packet owed
    logic [PW-1:0]                      last_sent;  // auto mode reference
    logic [clk_mgr_pkg::STAT_SEQ_W-1:0] seq_r;      // captured with the payload
    logic [PW-1:0]                      pay_r;
    logic                               wr_req;     // single or auto write
    logic                               auto_req;   // payload moved since last packet
    logic                               start;

    assign wr_req      = stat.stat_we && (stat.stat_mode != clk_mgr_pkg::STAT_OFF);
    assign auto_req    = (stat.stat_mode == clk_mgr_pkg::STAT_AUTO) &&
                         (stat.payload != last_sent);
    assign status_rq_o = pending && (state == ST_IDLE);
    assign start       = status_rq_o && status_start_i;

    always_comb begin
        case (state)
            ST_BYTE1: status_ad_o = {seq_r, pay_r[1:0]};
            ST_BYTE2: status_ad_o = {2'b00, pay_r[PW-1:2]};
            default:  status_ad_o = status_rq_o ? STATUS_ADDR : '0;  // bus idles at 0
        endcase
    end

    always_ff @(posedge mclk or posedge ffclk0_rst) begin
        if (ffclk0_rst) begin
            state     <= ST_IDLE;
            pending   <= 1'b0;
            last_sent <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) state <= ST_BYTE1;
                end
                ST_BYTE1: state <= ST_BYTE2;
                default:  state <= ST_IDLE;
            endcase
            if (start) begin
                pending   <= wr_req;              // only a fresh write re-arms at once
                last_sent <= stat.payload;
            end else if (wr_req || auto_req) begin
                pending <= 1'b1;                  // STAT_OFF write never sets it
            end
        end
    end

    // packet contents frozen at start
    always_ff @(posedge mclk) begin
        if (start) begin
            seq_r <= stat.stat_seq;
            pay_r <= stat.payload;
        end
    end

endmodule

// ==== rtl/status_if.sv ====
// status path from the clock controller to the status packet generator
`timescale 1ns/100ps

interface status_if;
    logic [clk_mgr_pkg::STAT_PAYLOAD_W-1:0] payload;   // registered status word
    logic                                   stat_we;   // one-cycle pulse on mode/seq write
    clk_mgr_pkg::stat_mode_t                stat_mode; // current packet mode
    logic [clk_mgr_pkg::STAT_SEQ_W-1:0]     stat_seq;  // sequence number for next packets

    // controller side drives everything
    modport ctrl (
        output payload,
        output stat_we,
        output stat_mode,
        output stat_seq
    );

    // generator side only listens
    modport gen (
        input payload,
        input stat_we,
        input stat_mode,
        input stat_seq
    );
endinterface

// ==== verification/tb_clk_gen.sv ====
// testbench clock and reset source, free-running system clock with a reset held for a few cycles
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter real PERIOD     = 10.0,  // ns
    parameter int  RST_CYCLES = 5      // mclk cycles in reset
) (
    output logic mclk,
    output logic ffclk0_rst
);
    initial begin
        mclk       = 1'b0;
        ffclk0_rst = 1'b1;                     // asserted from time zero
        repeat (RST_CYCLES) @(posedge mclk);
        @(negedge mclk);
        ffclk0_rst = 1'b0;                     // released away from the active edge
    end

    always #(PERIOD / 2.0) mclk = ~mclk;
endmodule

// ==== verification/tb_clk_mgr.sv ====
// simulation top that sends commands to the clock manager and checks clocks, locks and packets
`timescale 1ns/100ps

module tb_clk_mgr;
    localparam logic [15:0] CLK_ADDR    = 16'h728;
    localparam logic [15:0] STAT_REG    = 16'h729;  // status register with address bit 0 set
    localparam logic [7:0]  STATUS_ADDR = 8'h3a;
    localparam int          PCLK_DIV    = 4;
    localparam int          XCLK_DIV    = 2;
    localparam real         FF_PERIOD   = 16.0;     // ffclk0_i period in ns
    localparam int          TIMEOUT     = 400;      // mclk cycles per wait loop

    logic       mclk;
    logic       ffclk0_rst;
    logic       ffclk0_i;
    logic [7:0] cmd_ad_i;
    logic       cmd_stb_i;
    logic [7:0] status_ad_o;
    logic       status_rq_o;
    logic       status_start_i;
    logic [1:0] extra_status_i;
    logic       pclk_o;
    logic       xclk_o;
    logic [1:0] locked_o;
    logic       time_ref_o;

    integer seed;
    int     errors;
    int     test_errs;          // errors before the current test
    int     passed;
    int     failed;
    int     edges [3];          // rising edges of pclk, xclk, time_ref
    real    last_rise [3];
    real    period [3];         // latest measured period
    real    tref_high;          // latest time_ref high time

    tb_clk_gen #(
        .PERIOD     (10.0),
        .RST_CYCLES (5)
    ) clk_gen_i (.*);

    clk_mgr_top #(
        .CLK_ADDR    (CLK_ADDR),
        .STATUS_ADDR (STATUS_ADDR),
        .PCLK_DIV    (PCLK_DIV),
        .XCLK_DIV    (XCLK_DIV)
    ) DUT (.*);

    initial ffclk0_i = 1'b0;
    always #(FF_PERIOD / 2.0) ffclk0_i = ~ffclk0_i;   // external clock at 16 ns

    always @(posedge pclk_o) note_edge(0);
    always @(posedge xclk_o) note_edge(1);
    always @(posedge time_ref_o) note_edge(2);
    always @(negedge time_ref_o) tref_high = $realtime - last_rise[2];

    // request and address byte hold until start is taken
    assert property (@(posedge mclk) disable iff (ffclk0_rst)
        status_rq_o && !status_start_i |=> status_rq_o)
        else log_failure("status request dropped without start");
    assert property (@(posedge mclk) status_rq_o |-> status_ad_o == STATUS_ADDR)
        else log_failure("address byte missing while request is high");
    assert property (@(negedge mclk) ffclk0_rst |->
        !status_rq_o && !time_ref_o && status_ad_o == '0)
        else log_failure("outputs not cleared in reset");

    task automatic note_edge(input int k);
        period[k]    = $realtime - last_rise[k];
        last_rise[k] = $realtime;
        edges[k]++;
    endtask

    task automatic log_failure(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic note_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == test_errs) begin
            passed++;
            $display("test %0d %s: pass", num, name);
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", num, name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    // four bytes AL AH DL DH with the strobe on AL
    task automatic send_cmd(input logic [15:0] addr, input logic [15:0] data);
        logic [31:0] word;
        word = {data, addr};
        for (int i = 0; i < 4; i++) begin
            @(negedge mclk);
            cmd_stb_i = (i == 0);
            cmd_ad_i  = word[8*i +: 8];
        end
        @(negedge mclk);
        cmd_stb_i = 1'b0;
        cmd_ad_i  = '0;
    endtask

    task automatic wait_edges(input int k, input int n, input string what);
        int start;
        int cnt;
        start = edges[k];
        cnt   = 0;
        while (edges[k] < start + n && cnt < TIMEOUT) begin
            @(negedge mclk);
            cnt++;
        end
        if (edges[k] < start + n) note_timeout(what);
    endtask

    task automatic wait_lock(input int k, input logic level);
        int cnt;
        cnt = 0;
        while (locked_o[k] !== level && cnt < TIMEOUT) begin
            @(negedge mclk);
            cnt++;
        end
        if (locked_o[k] !== level) note_timeout($sformatf("locked_o[%0d] = %0b", k, level));
    endtask

    task automatic expect_stopped(input int k, input string what);
        int start;
        start = edges[k];
        repeat (30) @(negedge mclk);                   // several periods of either clock
        assert (edges[k] == start) else log_failure({what, " still toggling"});
    endtask

    task automatic expect_no_request(input string what);
        logic seen;
        seen = 1'b0;
        repeat (40) begin
            @(negedge mclk);
            seen = seen | status_rq_o;
        end
        assert (!seen) else log_failure(what);
    endtask

    // answers the request after 0..7 cycles and reads the bytes mid-cycle
    task automatic receive_packet(output logic [7:0] b0, output logic [7:0] b1,
                                  output logic [7:0] b2);
        int cnt;
        int delay;
        cnt = 0;
        b0  = '0;
        b1  = '0;
        b2  = '0;
        while (!status_rq_o && cnt < TIMEOUT) begin
            @(negedge mclk);
            cnt++;
        end
        if (!status_rq_o) begin
            note_timeout("status request");
        end else begin
            delay = $unsigned($random(seed)) % 8;
            repeat (delay) begin
                @(negedge mclk);
                assert (status_rq_o) else log_failure("request dropped before start");
            end
            b0             = status_ad_o;
            status_start_i = 1'b1;
            @(negedge mclk);
            status_start_i = 1'b0;
            b1             = status_ad_o;
            @(negedge mclk);
            b2             = status_ad_o;
            @(negedge mclk);
            assert (status_rq_o || status_ad_o == '0) else log_failure("status bus not idle");
        end
    endtask

    // {reset bits, ffclk0/pclk running, locked, extra} with both sources up
    function automatic logic [7:0] expected_payload(input logic [1:0] extra);
        return {2'b00, 2'b11, 2'b11, extra};
    endfunction

    task automatic check_packet(input logic [5:0] seq, input logic [7:0] payload);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        receive_packet(b0, b1, b2);
        assert (b0 == STATUS_ADDR) else log_failure($sformatf("address byte %h", b0));
        assert (b1 == {seq, payload[1:0]})
            else log_failure($sformatf("byte 1 %h, expected %h", b1, {seq, payload[1:0]}));
        assert (b2 == {2'b00, payload[7:2]})
            else log_failure($sformatf("byte 2 %h, expected %h", b2, {2'b00, payload[7:2]}));
    endtask

    initial begin
        int cnt;
        seed           = 21;
        cmd_ad_i       = '0;
        cmd_stb_i      = 1'b0;
        status_start_i = 1'b0;
        extra_status_i = 2'b10;
        cnt            = 0;
        while (ffclk0_rst !== 1'b0 && cnt < TIMEOUT) begin
            @(negedge mclk);
            cnt++;
        end
        if (ffclk0_rst !== 1'b0) note_timeout("reset release");

        assert (!status_rq_o) else log_failure("status request high after reset");
        wait_lock(0, 1'b1);
        wait_lock(1, 1'b1);
        wait_edges(0, 3, "pclk_o edges");
        assert (period[0] == PCLK_DIV * FF_PERIOD)
            else log_failure($sformatf("pclk_o period %0.1f ns", period[0]));
        wait_edges(1, 3, "xclk_o edges");
        assert (period[1] == XCLK_DIV * 10.0)
            else log_failure($sformatf("xclk_o period %0.1f ns", period[1]));
        finish_test(1, "reset and lock");

        wait_edges(2, 3, "time_ref_o edges");
        assert (period[2] == 80.0) else log_failure($sformatf("time_ref_o period %0.1f", period[2]));
        assert (tref_high == 40.0) else log_failure($sformatf("time_ref_o high %0.1f", tref_high));
        finish_test(2, "time reference");

        send_cmd(CLK_ADDR, 16'h0001);                  // pclk source in reset
        wait_lock(0, 1'b0);
        expect_stopped(0, "pclk_o");
        wait_edges(1, 3, "xclk_o while pclk is reset");
        send_cmd(CLK_ADDR, 16'h0000);
        wait_lock(0, 1'b1);
        send_cmd(CLK_ADDR, 16'h0008);                  // xclk power-down
        wait_lock(1, 1'b0);
        expect_stopped(1, "xclk_o");
        assert (locked_o[0]) else log_failure("pclk lock lost on xclk power-down");
        send_cmd(CLK_ADDR, 16'h0000);
        wait_lock(1, 1'b1);
        wait_edges(0, 3, "pclk_o after restart");      // running bits settle
        finish_test(3, "reset and power-down");

        send_cmd(STAT_REG, {8'h00, clk_mgr_pkg::STAT_SINGLE, 6'h2d});
        check_packet(6'h2d, expected_payload(extra_status_i));
        expect_no_request("second request after single write");
        finish_test(4, "single status packet");

        send_cmd(16'h072a, 16'h0003);                  // would reset both sources
        send_cmd(16'h072b, {8'h00, clk_mgr_pkg::STAT_SINGLE, 6'h11});
        expect_no_request("request after foreign command");
        assert (locked_o == 2'b11) else log_failure("lock lost after foreign command");
        finish_test(5, "address filter");

        send_cmd(STAT_REG, {8'h00, clk_mgr_pkg::STAT_AUTO, 6'h15});
        check_packet(6'h15, expected_payload(extra_status_i));
        for (int i = 0; i < 3; i++) begin
            @(negedge mclk);
            extra_status_i = extra_status_i + 2'd1;    // every step is a change
            check_packet(6'h15, expected_payload(extra_status_i));
        end
        send_cmd(STAT_REG, {8'h00, clk_mgr_pkg::STAT_OFF, 6'h15});
        @(negedge mclk);
        extra_status_i = ~extra_status_i;
        expect_no_request("request after status off");
        finish_test(6, "automatic status");

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end
endmodule
